// ==== common/vuad_pkg.sv ====
package vuad_pkg;

   ////////////////////
   // Geometry
   ////////////////////

   // Ways per set
   localparam int UA_WAYS = 12;

   // Stored entry: used parity, alloc parity, used, alloc
   localparam int UA_ENTRY_W = 2 * UA_WAYS + 2;

   ////////////////////
   // Operations
   ////////////////////

   typedef enum logic [3:0] {
      // Idle slot
      UA_OP_NONE    = 4'd0,
      // Used gains the hit way
      UA_OP_HIT     = 4'd1,
      // Full line store, used bit of the hit way clears
      UA_OP_WR64    = 4'd2,
      // Used loses the way, alloc gains it
      UA_OP_EVICT   = 4'd3,
      // Used gains the way, alloc loses it
      UA_OP_FILL    = 4'd4,
      // Alloc gains the hit way
      UA_OP_LOCK    = 4'd5,
      // Alloc loses the hit way
      UA_OP_UNLOCK  = 4'd6,
      // Entry replaced by diag data
      UA_OP_DIAG_WR = 4'd7,
      // Raw entry readout
      UA_OP_DIAG_RD = 4'd8
   } ua_op_e;

endpackage

// ==== logic/vuad_top.sv ====
`timescale 1ns/1ps

module vuad_top #(
   parameter int SET_BITS = 4
) (
   input  logic                            rclk,
   input  logic                            arst_n,
   // Request in C1
   input  vuad_pkg::ua_op_e                req_op,
   input  logic [SET_BITS-1:0]             req_set,
   input  logic [vuad_pkg::UA_WAYS-1:0]    req_way,
   input  logic [vuad_pkg::UA_ENTRY_W-1:0] diag_data,
   // Results in C2
   output logic                            ua_vld_c2,
   output logic [vuad_pkg::UA_WAYS-1:0]    vuad_dp_used_c2,
   output logic [vuad_pkg::UA_WAYS-1:0]    vuad_dp_alloc_c2,
   output logic [vuad_pkg::UA_ENTRY_W-1:0] diag_rd_ua_out,
   output logic                            used_rd_parity_c2,
   output logic                            alloc_rd_parity_c2
);
   import vuad_pkg::*;

   // Array ports
   logic [SET_BITS-1:0]   rd_set_c1;
   logic [UA_ENTRY_W-1:0] vuad_array_rd_data_c1;
   logic                  wr_en_c4;
   logic [SET_BITS-1:0]   wr_set_c4;
   logic [UA_ENTRY_W-1:0] vuad_array_wr_data_c4;

   // Selects
   logic                  vuad_sel_rd;
   logic                  vuad_sel_c2;
   logic                  vuad_sel_c2orc3;
   logic                  vuad_sel_c4;
   logic                  vuad_sel_c2_d1;
   logic                  sel_ua_wr_data_byp;

   // C3 controls and diag write
   logic [UA_WAYS-1:0]    hit_wayvld_c3;
   logic [UA_WAYS-1:0]    fill_way_c3;
   logic [UA_WAYS-1:0]    lru_way_sel_c3;
   logic                  vuad_evict_c3;
   logic                  wr64_inst_c3;
   logic                  alloc_set_cond_c3;
   logic                  alloc_rst_cond_c3;
   logic                  fbctl_vuad_bypassed_c3;
   logic                  bistordiag_wr_ua_c4;
   logic [UA_ENTRY_W-1:0] bistordiag_ua_data;

   vuad_ua_ctl #(
      .SET_BITS (SET_BITS)
   ) u_ctl (
      .rclk                   (rclk),
      .arst_n                 (arst_n),
      .req_op                 (req_op),
      .req_set                (req_set),
      .req_way                (req_way),
      .diag_data              (diag_data),
      .ua_vld_c2              (ua_vld_c2),
      .rd_set_c1              (rd_set_c1),
      .wr_en_c4               (wr_en_c4),
      .wr_set_c4              (wr_set_c4),
      .vuad_sel_rd            (vuad_sel_rd),
      .vuad_sel_c2            (vuad_sel_c2),
      .vuad_sel_c2orc3        (vuad_sel_c2orc3),
      .vuad_sel_c4            (vuad_sel_c4),
      .vuad_sel_c2_d1         (vuad_sel_c2_d1),
      .sel_ua_wr_data_byp     (sel_ua_wr_data_byp),
      .hit_wayvld_c3          (hit_wayvld_c3),
      .fill_way_c3            (fill_way_c3),
      .lru_way_sel_c3         (lru_way_sel_c3),
      .vuad_evict_c3          (vuad_evict_c3),
      .wr64_inst_c3           (wr64_inst_c3),
      .alloc_set_cond_c3      (alloc_set_cond_c3),
      .alloc_rst_cond_c3      (alloc_rst_cond_c3),
      .fbctl_vuad_bypassed_c3 (fbctl_vuad_bypassed_c3),
      .bistordiag_wr_ua_c4    (bistordiag_wr_ua_c4),
      .bistordiag_ua_data     (bistordiag_ua_data)
   );

   vuad_ua_dp u_dp (
      .rclk                   (rclk),
      .arst_n                 (arst_n),
      .vuad_array_rd_data_c1  (vuad_array_rd_data_c1),
      .vuad_sel_rd            (vuad_sel_rd),
      .vuad_sel_c2            (vuad_sel_c2),
      .vuad_sel_c2orc3        (vuad_sel_c2orc3),
      .vuad_sel_c4            (vuad_sel_c4),
      .vuad_sel_c2_d1         (vuad_sel_c2_d1),
      .sel_ua_wr_data_byp     (sel_ua_wr_data_byp),
      .hit_wayvld_c3          (hit_wayvld_c3),
      .fill_way_c3            (fill_way_c3),
      .lru_way_sel_c3         (lru_way_sel_c3),
      .vuad_evict_c3          (vuad_evict_c3),
      .wr64_inst_c3           (wr64_inst_c3),
      .alloc_set_cond_c3      (alloc_set_cond_c3),
      .alloc_rst_cond_c3      (alloc_rst_cond_c3),
      .fbctl_vuad_bypassed_c3 (fbctl_vuad_bypassed_c3),
      .bistordiag_wr_ua_c4    (bistordiag_wr_ua_c4),
      .bistordiag_ua_data     (bistordiag_ua_data),
      .vuad_array_wr_data_c4  (vuad_array_wr_data_c4),
      .vuad_dp_used_c2        (vuad_dp_used_c2),
      .vuad_dp_alloc_c2       (vuad_dp_alloc_c2),
      .diag_rd_ua_out         (diag_rd_ua_out),
      .used_rd_parity_c2      (used_rd_parity_c2),
      .alloc_rd_parity_c2     (alloc_rd_parity_c2)
   );

   vuad_ua_array #(
      .SET_BITS (SET_BITS)
   ) u_array (
      .rclk                  (rclk),
      .arst_n                (arst_n),
      .rd_set_c1             (rd_set_c1),
      .vuad_array_rd_data_c1 (vuad_array_rd_data_c1),
      .wr_en_c4              (wr_en_c4),
      .wr_set_c4             (wr_set_c4),
      .vuad_array_wr_data_c4 (vuad_array_wr_data_c4)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vuad testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing -Wno-fatal \
   --top-module tb_vuad_top \
   --Mdir "$BUILD_DIR" -o sim_vuad \
   -f vlog.f

# The simulator exit code is not used, the log search decides
"./$BUILD_DIR/sim_vuad" | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi
echo "Simulation finished, see $LOG"

// ==== test/tb_vuad_model.svh ====
`ifndef TB_VUAD_MODEL_SVH
`define TB_VUAD_MODEL_SVH

////////////////////
// Reference model
////////////////////

// One expected entry per set, same layout as the array
logic [UA_ENTRY_W-1:0] model_mem [1 << SET_BITS];

// Reset image, all zeros with zero parity
task automatic clear_model();
   model_mem = '{default: '0};
endtask

// Stored parity against its half, 1 on an error
function automatic logic half_parity_err(input logic par, input logic [UA_WAYS-1:0] half);
   return par ^ (^half);
endfunction

// Applies one op to the set, returns the entry seen before it
function automatic logic [UA_ENTRY_W-1:0] apply_op(
   input ua_op_e                op,
   input logic [SET_BITS-1:0]   set_idx,
   input logic [UA_WAYS-1:0]    way,
   input logic [UA_ENTRY_W-1:0] diag
);
   logic [UA_ENTRY_W-1:0] prev;
   logic [UA_WAYS-1:0]    used;
   logic [UA_WAYS-1:0]    alloc;
   logic                  full;
   prev  = model_mem[set_idx];
   used  = prev[2*UA_WAYS-1:UA_WAYS];
   alloc = prev[UA_WAYS-1:0];
   // Every way used or allocated before the op
   full  = &(used | alloc);
   case (op)
      UA_OP_HIT: used = used | way;
      // Store hit, the way goes back to unused
      UA_OP_WR64: used = used & ~way;
      UA_OP_EVICT: begin
         used  = used & ~way;
         alloc = alloc | way;
      end
      UA_OP_FILL: begin
         used  = used | way;
         alloc = alloc & ~way;
      end
      // Lock and unlock count as hits too
      UA_OP_LOCK: begin
         used  = used | way;
         alloc = alloc | way;
      end
      UA_OP_UNLOCK: begin
         used  = used | way;
         alloc = alloc & ~way;
      end
      default: begin
      end
   endcase
   if (full) begin
      used = '0;
   end
   if (op == UA_OP_DIAG_WR) begin
      model_mem[set_idx] = diag;
   end else if (op != UA_OP_DIAG_RD && op != UA_OP_NONE) begin
      model_mem[set_idx] = {^used, ^alloc, used, alloc};
   end
   return prev;
endfunction

`endif

// ==== test/tb_vuad_top.sv ====
`timescale 1ns/1ps

module tb_vuad_top;
   import vuad_pkg::*;

   localparam int SET_BITS     = 4;
   localparam int DRAIN_CYCLES = 50;
   localparam int DIAG_GAP     = 6;

   logic                  rclk;
   logic                  arst_n;
   ua_op_e                req_op;
   logic [SET_BITS-1:0]   req_set;
   logic [UA_WAYS-1:0]    req_way;
   logic [UA_ENTRY_W-1:0] diag_data;
   logic                  ua_vld_c2;
   logic [UA_WAYS-1:0]    vuad_dp_used_c2;
   logic [UA_WAYS-1:0]    vuad_dp_alloc_c2;
   logic [UA_ENTRY_W-1:0] diag_rd_ua_out;
   logic                  used_rd_parity_c2;
   logic                  alloc_rd_parity_c2;

   // Expected C2 results in issue order
   logic [UA_ENTRY_W-1:0] exp_entry_q [$];
   logic                  exp_rd_q [$];
   logic [UA_ENTRY_W-1:0] exp_entry;
   logic                  exp_rd;

   int seed;
   int slot_count;
   int cycle_count;

   `include "tb_vuad_model.svh"

   vuad_top #(
      .SET_BITS (SET_BITS)
   ) dut (
      .rclk               (rclk),
      .arst_n             (arst_n),
      .req_op             (req_op),
      .req_set            (req_set),
      .req_way            (req_way),
      .diag_data          (diag_data),
      .ua_vld_c2          (ua_vld_c2),
      .vuad_dp_used_c2    (vuad_dp_used_c2),
      .vuad_dp_alloc_c2   (vuad_dp_alloc_c2),
      .diag_rd_ua_out     (diag_rd_ua_out),
      .used_rd_parity_c2  (used_rd_parity_c2),
      .alloc_rd_parity_c2 (alloc_rd_parity_c2)
   );

   initial rclk = 1'b0;
   always #4 rclk = ~rclk;

   ////////////////////
   // Helpers
   ////////////////////

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   // One request slot driven on the falling edge
   task automatic issue_op(input ua_op_e op, input logic [SET_BITS-1:0] set_idx,
                           input logic [UA_WAYS-1:0] way, input logic [UA_ENTRY_W-1:0] diag);
      @(negedge rclk);
      req_op    = op;
      req_set   = set_idx;
      req_way   = way;
      diag_data = diag;
      slot_count++;
      if (op != UA_OP_NONE) begin
         exp_entry_q.push_back(apply_op(op, set_idx, way, diag));
         exp_rd_q.push_back(op == UA_OP_DIAG_RD);
      end
   endtask

   task automatic issue_idle(input int cycles);
      repeat (cycles) issue_op(UA_OP_NONE, '0, '0, '0);
   endtask

   // Diag ops need an empty pipeline on both sides
   task automatic issue_diag(input ua_op_e op, input logic [SET_BITS-1:0] set_idx,
                             input logic [UA_ENTRY_W-1:0] diag);
      issue_idle(DIAG_GAP);
      issue_op(op, set_idx, '0, diag);
      issue_idle(DIAG_GAP);
   endtask

   function automatic logic [UA_WAYS-1:0] random_way();
      int idx;
      idx = int'($unsigned($random(seed)) % UA_WAYS);
      return UA_WAYS'(1) << idx;
   endfunction

   function automatic ua_op_e random_update_op();
      case ($unsigned($random(seed)) % 6)
         0: return UA_OP_HIT;
         1: return UA_OP_WR64;
         2: return UA_OP_EVICT;
         3: return UA_OP_FILL;
         4: return UA_OP_LOCK;
         default: return UA_OP_UNLOCK;
      endcase
   endfunction

   // Diag entry with optional flipped parity
   // Flip bit 1 is used and bit 0 is alloc
   function automatic logic [UA_ENTRY_W-1:0] build_diag_entry(
      input logic [UA_WAYS-1:0] used, input logic [UA_WAYS-1:0] alloc, input logic [1:0] flip);
      return {(^used) ^ flip[1], (^alloc) ^ flip[0], used, alloc};
   endfunction

   ////////////////////
   // Compare and watchdog
   ////////////////////

   // Outputs are stable on the falling edge
   always @(negedge rclk) begin
      if (arst_n && ua_vld_c2) begin
         if (exp_entry_q.size() == 0) begin
            $display("ERROR: output valid with no operation in flight");
            abort_run();
         end else begin
            exp_entry = exp_entry_q.pop_front();
            exp_rd    = exp_rd_q.pop_front();
            check_value("vuad_dp_used_c2", vuad_dp_used_c2, exp_entry[2*UA_WAYS-1:UA_WAYS]);
            check_value("vuad_dp_alloc_c2", vuad_dp_alloc_c2, exp_entry[UA_WAYS-1:0]);
            // Raw entry and parity only for diag reads
            if (exp_rd) begin
               check_value("diag_rd_ua_out", diag_rd_ua_out, exp_entry);
               check_value("used_rd_parity_c2", used_rd_parity_c2,
                  half_parity_err(exp_entry[2*UA_WAYS+1], exp_entry[2*UA_WAYS-1:UA_WAYS]));
               check_value("alloc_rd_parity_c2", alloc_rd_parity_c2,
                  half_parity_err(exp_entry[2*UA_WAYS], exp_entry[UA_WAYS-1:0]));
            end
         end
      end
   end

   // Limit grows with every issued slot
   always @(posedge rclk) begin
      if (arst_n) begin
         cycle_count++;
         if (cycle_count > slot_count + DRAIN_CYCLES) begin
            $display("ERROR: timeout waiting for outputs");
            abort_run();
         end
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      seed        = 16118;
      slot_count  = 0;
      cycle_count = 0;
      req_op      = UA_OP_NONE;
      req_set     = '0;
      req_way     = '0;
      diag_data   = '0;
      arst_n      = 1'b0;
      clear_model();
      repeat (4) @(posedge rclk);
      @(negedge rclk);
      arst_n = 1'b1;

      // Quiet pipeline then raw reads of the cleared array
      for (int i = 0; i < 8; i++) begin
         issue_idle(1);
         check_value("ua_vld_c2", ua_vld_c2, 0);
      end
      issue_diag(UA_OP_DIAG_RD, 0, '0);
      issue_diag(UA_OP_DIAG_RD, 9, '0);
      issue_diag(UA_OP_DIAG_RD, 15, '0);

      // Each op type on sets far apart
      for (int r = 0; r < 4; r++) begin
         issue_op(UA_OP_HIT, SET_BITS'(4 * (r % 4)), random_way(), '0);
         issue_op(UA_OP_FILL, SET_BITS'(4 * ((r + 1) % 4)), random_way(), '0);
         issue_op(UA_OP_EVICT, SET_BITS'(4 * ((r + 2) % 4)), random_way(), '0);
         issue_op(UA_OP_LOCK, SET_BITS'(4 * ((r + 3) % 4)), random_way(), '0);
         issue_op(UA_OP_UNLOCK, SET_BITS'(4 * (r % 4)), random_way(), '0);
         issue_op(UA_OP_WR64, SET_BITS'(4 * ((r + 1) % 4)), random_way(), '0);
      end

      // Two sets back to back so every bypass stage is in play
      for (int n = 0; n < 80; n++) begin
         if ($unsigned($random(seed)) % 5 == 0) begin
            issue_idle(1);
         end else begin
            issue_op(random_update_op(), SET_BITS'(2 + $unsigned($random(seed)) % 2),
                     random_way(), '0);
         end
      end

      // Fill used or alloc to all ones and watch used clear
      for (int g = 0; g < 2; g++) begin
         for (int w = 0; w < UA_WAYS + 3; w++) begin
            if (w < 6) begin
               issue_op(UA_OP_LOCK, SET_BITS'(6 + g), UA_WAYS'(1) << w, '0);
            end else begin
               issue_op(UA_OP_HIT, SET_BITS'(6 + g), UA_WAYS'(1) << (w % UA_WAYS), '0);
            end
            // Second pass goes through the array path
            if (g == 1) begin
               issue_idle(5);
            end
         end
      end

      // Diag write and readback with good and flipped parity
      issue_diag(UA_OP_DIAG_WR, 9, build_diag_entry(12'ha53, 12'h0c1, 2'b00));
      issue_diag(UA_OP_DIAG_RD, 9, '0);
      issue_op(UA_OP_HIT, 9, random_way(), '0);
      issue_diag(UA_OP_DIAG_WR, 10, build_diag_entry(12'h3f0, 12'h00f, 2'b10));
      issue_diag(UA_OP_DIAG_RD, 10, '0);
      issue_diag(UA_OP_DIAG_WR, 11, build_diag_entry(12'h001, 12'h7e0, 2'b01));
      issue_diag(UA_OP_DIAG_RD, 11, '0);

      // Long random run over all sets
      for (int n = 0; n < 300; n++) begin
         if ($unsigned($random(seed)) % 25 == 0) begin
            if ($unsigned($random(seed)) % 2 == 0) begin
               issue_diag(UA_OP_DIAG_WR, SET_BITS'($unsigned($random(seed))),
                          UA_ENTRY_W'($unsigned($random(seed))));
            end else begin
               issue_diag(UA_OP_DIAG_RD, SET_BITS'($unsigned($random(seed))), '0);
            end
         end else if ($unsigned($random(seed)) % 8 == 0) begin
            issue_idle(1);
         end else begin
            issue_op(random_update_op(), SET_BITS'($unsigned($random(seed))),
                     random_way(), '0);
         end
      end

      // Drain the pipeline
      issue_idle(DIAG_GAP);
      while (exp_entry_q.size() != 0) begin
         @(negedge rclk);
      end
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+test
common/vuad_pkg.sv
vuad/vuad_ua_array.sv
vuad/vuad_ua_ctl.sv
vuad/vuad_ua_dp.sv
logic/vuad_top.sv
test/tb_vuad_top.sv

// ==== vuad/vuad_ua_array.sv ====
`timescale 1ns/1ps

module vuad_ua_array #(
   parameter int SET_BITS = 4
) (
   input  logic                            rclk,
   input  logic                            arst_n,
   // Read port, C1
   input  logic [SET_BITS-1:0]             rd_set_c1,
   output logic [vuad_pkg::UA_ENTRY_W-1:0] vuad_array_rd_data_c1,
   // Write port, presented in C4
   input  logic                            wr_en_c4,
   input  logic [SET_BITS-1:0]             wr_set_c4,
   input  logic [vuad_pkg::UA_ENTRY_W-1:0] vuad_array_wr_data_c4
);
   import vuad_pkg::*;

   localparam int NUM_SETS = 1 << SET_BITS;

   // One entry per set
   logic [UA_ENTRY_W-1:0] mem [NUM_SETS];

   // Write port staged into C5
   logic                  wr_en_c5;
   logic [SET_BITS-1:0]   wr_set_c5;
   logic [UA_ENTRY_W-1:0] wr_data_c5;

   ////////////////////
   // Write side
   ////////////////////

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_en_c5 <= 1'b0;
      end else begin
         wr_en_c5 <= wr_en_c4;
      end
   end

   always_ff @(posedge rclk) begin
      wr_set_c5  <= wr_set_c4;
      wr_data_c5 <= vuad_array_wr_data_c4;
   end

   // Entry lands at the end of C5
   // Zero data with zero parity after reset
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_SETS; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en_c5) begin
         mem[wr_set_c5] <= wr_data_c5;
      end
   end

   ////////////////////
   // Read side
   ////////////////////

   // Flow-through read, no C5 forwarding here
   assign vuad_array_rd_data_c1 = mem[rd_set_c1];

endmodule

// ==== vuad/vuad_ua_ctl.sv ====
`timescale 1ns/1ps

module vuad_ua_ctl #(
   parameter int SET_BITS = 4
) (
   input  logic                            rclk,
   input  logic                            arst_n,
   // Request, sampled at the end of C1
   input  vuad_pkg::ua_op_e                req_op,
   input  logic [SET_BITS-1:0]             req_set,
   input  logic [vuad_pkg::UA_WAYS-1:0]    req_way,
   input  logic [vuad_pkg::UA_ENTRY_W-1:0] diag_data,
   output logic                            ua_vld_c2,
   // Array control
   output logic [SET_BITS-1:0]             rd_set_c1,
   output logic                            wr_en_c4,
   output logic [SET_BITS-1:0]             wr_set_c4,
   // Bypass selects
   output logic                            vuad_sel_rd,
   output logic                            vuad_sel_c2,
   output logic                            vuad_sel_c2orc3,
   output logic                            vuad_sel_c4,
   output logic                            vuad_sel_c2_d1,
   output logic                            sel_ua_wr_data_byp,
   // C3 update controls
   output logic [vuad_pkg::UA_WAYS-1:0]    hit_wayvld_c3,
   output logic [vuad_pkg::UA_WAYS-1:0]    fill_way_c3,
   output logic [vuad_pkg::UA_WAYS-1:0]    lru_way_sel_c3,
   output logic                            vuad_evict_c3,
   output logic                            wr64_inst_c3,
   output logic                            alloc_set_cond_c3,
   output logic                            alloc_rst_cond_c3,
   output logic                            fbctl_vuad_bypassed_c3,
   // Diagnostic write
   output logic                            bistordiag_wr_ua_c4,
   output logic [vuad_pkg::UA_ENTRY_W-1:0] bistordiag_ua_data
);
   import vuad_pkg::*;

   // Per-stage state, index is the stage number
   logic                  vld [2:6];
   ua_op_e                op  [2:6];
   logic [SET_BITS-1:0]   set [2:6];
   logic [UA_WAYS-1:0]    way_c2;
   logic [UA_WAYS-1:0]    way_c3;
   logic [UA_ENTRY_W-1:0] diag_c2;
   logic [UA_ENTRY_W-1:0] diag_c3;

   // C1 set hits an older update in stage 2..5
   logic [5:2]            match;

   ////////////////////
   // Stage pipeline
   ////////////////////

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int s = 2; s <= 6; s++) begin
            vld[s] <= 1'b0;
            op[s]  <= UA_OP_NONE;
         end
         vuad_sel_c2_d1 <= 1'b0;
      end else begin
         vld[2] <= (req_op != UA_OP_NONE);
         op[2]  <= req_op;
         for (int s = 3; s <= 6; s++) begin
            vld[s] <= vld[s-1];
            op[s]  <= op[s-1];
         end
         // C2 match follows the op into C2
         vuad_sel_c2_d1 <= vuad_sel_c2;
      end
   end

   // Set, way and diag payload
   always_ff @(posedge rclk) begin
      set[2] <= req_set;
      for (int s = 3; s <= 6; s++) begin
         set[s] <= set[s-1];
      end
      way_c2             <= req_way;
      way_c3             <= way_c2;
      diag_c2            <= diag_data;
      diag_c3            <= diag_c2;
      bistordiag_ua_data <= diag_c3;
   end

   assign ua_vld_c2 = vld[2];
   assign rd_set_c1 = req_set;

   ////////////////////
   // Bypass selects
   ////////////////////

   // Diag ops never forward, they are kept idle-spaced
   always_comb begin
      for (int s = 2; s <= 5; s++) begin
         match[s] = vld[s] && (set[s] == req_set) &&
                    (op[s] != UA_OP_DIAG_WR) && (op[s] != UA_OP_DIAG_RD);
      end
   end

   // Youngest matching stage wins
   assign vuad_sel_rd     = ~|match;
   assign vuad_sel_c2     = match[2];
   assign vuad_sel_c2orc3 = match[2] | match[3];
   assign vuad_sel_c4     = match[4] & ~match[2] & ~match[3];
   // C5 is the fallback when none of the above

   // C6 wrote at the edge the raw C2 read was sampled
   assign sel_ua_wr_data_byp = vld[6] && (op[6] != UA_OP_DIAG_RD) &&
                               (set[6] == set[2]);

   ////////////////////
   // C3 decode
   ////////////////////

   always_comb begin
      hit_wayvld_c3          = '0;
      fill_way_c3            = '0;
      lru_way_sel_c3         = '0;
      vuad_evict_c3          = 1'b0;
      wr64_inst_c3           = 1'b0;
      fbctl_vuad_bypassed_c3 = 1'b0;
      if (vld[3]) begin
         case (op[3])
            // Lock and unlock are hits too, so the way turns used
            UA_OP_HIT, UA_OP_LOCK, UA_OP_UNLOCK: begin
               hit_wayvld_c3 = way_c3;
            end
            UA_OP_WR64: begin
               hit_wayvld_c3 = way_c3;
               wr64_inst_c3  = 1'b1;
            end
            UA_OP_EVICT: begin
               lru_way_sel_c3 = way_c3;
               vuad_evict_c3  = 1'b1;
            end
            UA_OP_FILL: begin
               fill_way_c3            = way_c3;
               fbctl_vuad_bypassed_c3 = 1'b1;
            end
            default: begin
            end
         endcase
      end
   end

   // Alloc set/clear qualify the hit way
   assign alloc_set_cond_c3 = vld[3] && (op[3] == UA_OP_LOCK);
   assign alloc_rst_cond_c3 = vld[3] && (op[3] == UA_OP_UNLOCK);

   ////////////////////
   // C4 write control
   ////////////////////

   assign bistordiag_wr_ua_c4 = vld[4] && (op[4] == UA_OP_DIAG_WR);
   assign wr_en_c4            = vld[4] && (op[4] != UA_OP_DIAG_RD);
   assign wr_set_c4           = set[4];

endmodule

// ==== vuad/vuad_ua_dp.sv ====
`timescale 1ns/1ps

module vuad_ua_dp (
   input  logic                            rclk,
   input  logic                            arst_n,
   // Array read data in C1
   input  logic [vuad_pkg::UA_ENTRY_W-1:0] vuad_array_rd_data_c1,
   // Bypass selects
   input  logic                            vuad_sel_rd,
   input  logic                            vuad_sel_c2,
   input  logic                            vuad_sel_c2orc3,
   input  logic                            vuad_sel_c4,
   input  logic                            vuad_sel_c2_d1,
   input  logic                            sel_ua_wr_data_byp,
   // C3 update controls
   input  logic [vuad_pkg::UA_WAYS-1:0]    hit_wayvld_c3,
   input  logic [vuad_pkg::UA_WAYS-1:0]    fill_way_c3,
   input  logic [vuad_pkg::UA_WAYS-1:0]    lru_way_sel_c3,
   input  logic                            vuad_evict_c3,
   input  logic                            wr64_inst_c3,
   input  logic                            alloc_set_cond_c3,
   input  logic                            alloc_rst_cond_c3,
   input  logic                            fbctl_vuad_bypassed_c3,
   // Diagnostic write
   input  logic                            bistordiag_wr_ua_c4,
   input  logic [vuad_pkg::UA_ENTRY_W-1:0] bistordiag_ua_data,
   // Array write data
   output logic [vuad_pkg::UA_ENTRY_W-1:0] vuad_array_wr_data_c4,
   // C2 results
   output logic [vuad_pkg::UA_WAYS-1:0]    vuad_dp_used_c2,
   output logic [vuad_pkg::UA_WAYS-1:0]    vuad_dp_alloc_c2,
   output logic [vuad_pkg::UA_ENTRY_W-1:0] diag_rd_ua_out,
   output logic                            used_rd_parity_c2,
   output logic                            alloc_rd_parity_c2
);
   import vuad_pkg::*;

   // Entry field positions
   localparam int U_PAR = 2 * UA_WAYS + 1;
   localparam int A_PAR = 2 * UA_WAYS;
   localparam int U_HI  = 2 * UA_WAYS - 1;
   localparam int U_LO  = UA_WAYS;
   localparam int A_HI  = UA_WAYS - 1;

   // Used half
   logic [UA_WAYS-1:0]    used_c1;
   logic [UA_WAYS-1:0]    used_byp_c1;
   logic [UA_WAYS-1:0]    used_byp_c2c3;
   logic [UA_WAYS-1:0]    used_byp_c4c5;
   logic [UA_WAYS-1:0]    used_c2;
   logic [UA_WAYS-1:0]    used_byp_c2_in;
   logic [UA_WAYS-1:0]    used_c3;
   logic [UA_WAYS-1:0]    used_byp_c3_in;
   logic [UA_WAYS-1:0]    used_c4;

   // Alloc half
   logic [UA_WAYS-1:0]    alloc_c1;
   logic [UA_WAYS-1:0]    alloc_byp_c1;
   logic [UA_WAYS-1:0]    alloc_byp_c2c3;
   logic [UA_WAYS-1:0]    alloc_byp_c4c5;
   logic [UA_WAYS-1:0]    alloc_c2;
   logic [UA_WAYS-1:0]    alloc_byp_c2_in;
   logic [UA_WAYS-1:0]    alloc_c3;
   logic [UA_WAYS-1:0]    alloc_byp_c3_in;
   logic [UA_WAYS-1:0]    alloc_c4;

   // Parity, bit 1 used and bit 0 alloc
   logic [1:0]            parity_wr_c3;
   logic [1:0]            parity_wr_data_c4;

   // Write data after the diag mux, and the raw read
   logic [UA_ENTRY_W-1:0] wr_data_c5;
   logic [UA_ENTRY_W-1:0] wr_data_c6;
   logic [UA_ENTRY_W-1:0] rd_byp_c2;
   logic [UA_ENTRY_W-1:0] rd_c2;

   ////////////////////
   // C1 bypass muxes
   ////////////////////

   // C2 or C3 against C4 or C5
   assign used_byp_c2c3  = vuad_sel_c2 ? used_byp_c2_in : used_byp_c3_in;
   assign used_byp_c4c5  = vuad_sel_c4 ? used_c4 : wr_data_c5[U_HI:U_LO];
   assign used_byp_c1    = vuad_sel_c2orc3 ? used_byp_c2c3 : used_byp_c4c5;
   assign used_c1        = vuad_sel_rd ? vuad_array_rd_data_c1[U_HI:U_LO] : used_byp_c1;

   assign alloc_byp_c2c3 = vuad_sel_c2 ? alloc_byp_c2_in : alloc_byp_c3_in;
   assign alloc_byp_c4c5 = vuad_sel_c4 ? alloc_c4 : wr_data_c5[A_HI:0];
   assign alloc_byp_c1   = vuad_sel_c2orc3 ? alloc_byp_c2c3 : alloc_byp_c4c5;
   assign alloc_c1       = vuad_sel_rd ? vuad_array_rd_data_c1[A_HI:0] : alloc_byp_c1;

   ////////////////////
   // C2 and C3
   ////////////////////

   // Op in C2 took the older op's C2 value
   // Swap in that op's freshly updated C3 value
   assign used_byp_c2_in  = vuad_sel_c2_d1 ? used_byp_c3_in : used_c2;
   assign alloc_byp_c2_in = vuad_sel_c2_d1 ? alloc_byp_c3_in : alloc_c2;

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         used_c2   <= '0;
         alloc_c2  <= '0;
         used_c3   <= '0;
         alloc_c3  <= '0;
         rd_byp_c2 <= '0;
      end else begin
         used_c2   <= used_c1;
         alloc_c2  <= alloc_c1;
         used_c3   <= used_byp_c2_in;
         alloc_c3  <= alloc_byp_c2_in;
         rd_byp_c2 <= vuad_array_rd_data_c1;
      end
   end

   // State seen by this op, every older op applied
   assign vuad_dp_used_c2  = used_byp_c2_in;
   assign vuad_dp_alloc_c2 = alloc_byp_c2_in;

   ////////////////////
   // C3 update
   ////////////////////

   // All ways used or allocated resets the used bits
   assign used_byp_c3_in =
      (used_c3 | fill_way_c3 | hit_wayvld_c3) &
      ~(({UA_WAYS{vuad_evict_c3}} & lru_way_sel_c3) |
        ({UA_WAYS{wr64_inst_c3}} & hit_wayvld_c3) |
        {UA_WAYS{&(used_c3 | alloc_c3)}});

   // Lock and evict set, unlock and fill clear
   assign alloc_byp_c3_in =
      (alloc_c3 |
       ({UA_WAYS{alloc_set_cond_c3}} & hit_wayvld_c3) |
       ({UA_WAYS{vuad_evict_c3}} & lru_way_sel_c3)) &
      ~(({UA_WAYS{alloc_rst_cond_c3}} & hit_wayvld_c3) |
        ({UA_WAYS{fbctl_vuad_bypassed_c3}} & fill_way_c3));

   // Even parity per half
   assign parity_wr_c3 = {^used_byp_c3_in, ^alloc_byp_c3_in};

   ////////////////////
   // C4 to C6 write data
   ////////////////////

   always_ff @(posedge rclk) begin
      used_c4           <= used_byp_c3_in;
      alloc_c4          <= alloc_byp_c3_in;
      parity_wr_data_c4 <= parity_wr_c3;
      wr_data_c5        <= vuad_array_wr_data_c4;
      wr_data_c6        <= wr_data_c5;
   end

   // Diag write replaces the whole entry, parity included
   assign vuad_array_wr_data_c4 = bistordiag_wr_ua_c4 ? bistordiag_ua_data :
                                  {parity_wr_data_c4, used_c4, alloc_c4};

   ////////////////////
   // Raw read in C2
   ////////////////////

   // C6 data landed in the array on the sampling edge
   assign rd_c2          = sel_ua_wr_data_byp ? wr_data_c6 : rd_byp_c2;
   assign diag_rd_ua_out = rd_c2;

   // Stored parity against its half, 1 flags an error
   assign used_rd_parity_c2  = ^{rd_c2[U_PAR], rd_c2[U_HI:U_LO]};
   assign alloc_rd_parity_c2 = ^{rd_c2[A_PAR], rd_c2[A_HI:0]};

endmodule
